// File: verilog/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

	// datapath and register file widths
	localparam int DATA_W = 16;
	localparam int REG_W  = 3;

	// tag 0 means the value is present in the register file or the entry.
	// tag k in 1..7 names reservation station entry k-1
	localparam int TAG_W  = 3;
	localparam int MAX_RS = 7;

	// fixed multiplier depth, the CDB schedule depends on it
	localparam int MULT_STAGES = 3;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_XOR = 3'd3,
		OP_MUL = 3'd4
	} opcode_e;

	// class of a station entry, picks the functional unit it issues to
	typedef enum logic {
		FU_ALU  = 1'b0,
		FU_MULT = 1'b1
	} fu_class_e;

endpackage

`default_nettype wire

// File: verilog/reg_status.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              dispatch_fire,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rd,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rs1,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rs2,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   alloc_tag,
	output logic [tomasulo_pkg::TAG_W-1:0]   src1_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  src1_value,
	output logic [tomasulo_pkg::TAG_W-1:0]   src2_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  src2_value,
	input  wire                              cdb_valid,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   cdb_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  cdb_value,
	input  wire  [tomasulo_pkg::REG_W-1:0]   read_addr,
	output logic [tomasulo_pkg::DATA_W-1:0]  read_data
);
	import tomasulo_pkg::*;

	localparam int NUM_REGS = 2 ** REG_W;

	logic [DATA_W-1:0] value_q [NUM_REGS];
	logic [TAG_W-1:0]  tag_q   [NUM_REGS];  // producer tag, 0 when value_q is current

	// operand read with same-cycle CDB forwarding
	always_comb begin
		src1_tag   = tag_q[dispatch_rs1];
		src1_value = value_q[dispatch_rs1];
		if (cdb_valid && src1_tag != '0 && src1_tag == cdb_tag) begin
			src1_tag   = '0;
			src1_value = cdb_value;
		end
	end

	always_comb begin
		src2_tag   = tag_q[dispatch_rs2];
		src2_value = value_q[dispatch_rs2];
		if (cdb_valid && src2_tag != '0 && src2_tag == cdb_tag) begin
			src2_tag   = '0;
			src2_value = cdb_value;
		end
	end

	assign read_data = value_q[read_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				value_q[i] <= DATA_W'(i);  // register i starts out holding i
				tag_q[i]   <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				// only the newest producer may write, older results are dropped
				if (cdb_valid && tag_q[i] != '0 && tag_q[i] == cdb_tag) begin
					value_q[i] <= cdb_value;
					tag_q[i]   <= '0;
				end
				if (dispatch_fire && dispatch_rd == REG_W'(i)) begin
					tag_q[i] <= alloc_tag;  // rename wins over a same-edge writeback
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/rs.sv
`timescale 1ns/1ps
`default_nettype none

module rs #(
	parameter int NUM_ALU_RS  = 3,
	parameter int NUM_MULT_RS = 2
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              dispatch_valid,
	input  wire  tomasulo_pkg::opcode_e      dispatch_op,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   src1_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  src1_value,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   src2_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  src2_value,
	output logic                             dispatch_ready,
	output logic                             dispatch_fire,
	output logic [tomasulo_pkg::TAG_W-1:0]   alloc_tag,
	output logic                             alu_issue_valid,
	output tomasulo_pkg::opcode_e            alu_issue_op,
	output logic [tomasulo_pkg::TAG_W-1:0]   alu_issue_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  alu_a,
	output logic [tomasulo_pkg::DATA_W-1:0]  alu_b,
	input  wire                              alu_issue_ready,
	output logic                             mult_issue_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]   mult_issue_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  mult_a,
	output logic [tomasulo_pkg::DATA_W-1:0]  mult_b,
	input  wire                              cdb_valid,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   cdb_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  cdb_value,
	output logic                             rs_empty
);
	import tomasulo_pkg::*;

	localparam int NUM_RS = NUM_ALU_RS + NUM_MULT_RS;

	if (NUM_RS > MAX_RS) begin : g_size_check
		$error("rs: %0d entries do not fit in the tag space", NUM_RS);
	end

	fu_class_e         cls_q   [NUM_RS];
	opcode_e           op_q    [NUM_RS];
	logic [TAG_W-1:0]  tag1_q  [NUM_RS];
	logic [DATA_W-1:0] val1_q  [NUM_RS];
	logic [TAG_W-1:0]  tag2_q  [NUM_RS];
	logic [DATA_W-1:0] val2_q  [NUM_RS];
	logic [NUM_RS-1:0] busy_q;
	logic [NUM_RS-1:0] issued_q;
	logic [NUM_RS-1:0] ready_q;  // both tags were 0 on the previous cycle
	logic [NUM_RS-1:0] can_issue;

	fu_class_e        disp_cls;
	logic             alloc_found;
	logic [TAG_W-1:0] alloc_idx;
	logic [TAG_W-1:0] alu_idx;
	logic [TAG_W-1:0] mult_idx;
	logic             alu_fire;
	logic [TAG_W-1:0] cdb_idx;

	assign disp_cls  = (dispatch_op == OP_MUL) ? FU_MULT : FU_ALU;
	assign can_issue = busy_q & ~issued_q & ready_q;

	// descending scan so the lowest index is the one left standing
	always_comb begin
		alloc_found      = 1'b0;
		alloc_idx        = '0;
		alu_issue_valid  = 1'b0;
		alu_idx          = '0;
		mult_issue_valid = 1'b0;
		mult_idx         = '0;
		for (int i = NUM_RS - 1; i >= 0; i--) begin
			if (!busy_q[i] && cls_q[i] == disp_cls) begin
				alloc_found = 1'b1;
				alloc_idx   = TAG_W'(i);
			end
			if (can_issue[i] && cls_q[i] == FU_ALU) begin
				alu_issue_valid = 1'b1;
				alu_idx         = TAG_W'(i);
			end
			if (can_issue[i] && cls_q[i] == FU_MULT) begin
				mult_issue_valid = 1'b1;
				mult_idx         = TAG_W'(i);
			end
		end
	end

	assign dispatch_ready = alloc_found;
	assign dispatch_fire  = dispatch_valid && dispatch_ready;
	assign alloc_tag      = alloc_idx + TAG_W'(1);

	assign alu_fire      = alu_issue_valid && alu_issue_ready;
	assign alu_issue_op  = op_q[alu_idx];
	assign alu_issue_tag = alu_idx + TAG_W'(1);
	assign alu_a         = val1_q[alu_idx];
	assign alu_b         = val2_q[alu_idx];

	assign mult_issue_tag = mult_idx + TAG_W'(1);  // multiplier always accepts
	assign mult_a         = val1_q[mult_idx];
	assign mult_b         = val2_q[mult_idx];

	assign rs_empty = ~|busy_q;
	assign cdb_idx  = cdb_tag - TAG_W'(1);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_RS; i++) begin
				cls_q[i] <= (i < NUM_ALU_RS) ? FU_ALU : FU_MULT;  // alu region first
			end
			busy_q   <= '0;
			issued_q <= '0;
			ready_q  <= '0;
		end else begin
			for (int i = 0; i < NUM_RS; i++) begin
				ready_q[i] <= busy_q[i] && tag1_q[i] == '0 && tag2_q[i] == '0;
				if (cdb_valid && busy_q[i] && tag1_q[i] != '0 && tag1_q[i] == cdb_tag) begin
					tag1_q[i] <= '0;
					val1_q[i] <= cdb_value;
				end
				if (cdb_valid && busy_q[i] && tag2_q[i] != '0 && tag2_q[i] == cdb_tag) begin
					tag2_q[i] <= '0;
					val2_q[i] <= cdb_value;
				end
				if ((alu_fire && alu_idx == TAG_W'(i)) ||
						(mult_issue_valid && mult_idx == TAG_W'(i))) begin
					issued_q[i] <= 1'b1;
				end
				if (cdb_valid && cdb_tag == TAG_W'(i + 1)) begin  // result is out, free it
					busy_q[i]   <= 1'b0;
					issued_q[i] <= 1'b0;
					ready_q[i]  <= 1'b0;
				end
				if (dispatch_fire && alloc_idx == TAG_W'(i)) begin
					busy_q[i]   <= 1'b1;
					issued_q[i] <= 1'b0;
					ready_q[i]  <= 1'b0;
					op_q[i]     <= dispatch_op;
					tag1_q[i]   <= src1_tag;
					val1_q[i]   <= src1_value;
					tag2_q[i]   <= src2_tag;
					val2_q[i]   <= src2_value;
				end
			end
		end
	end

	a_alu_operands: assert property (@(posedge clock) disable iff (reset)
		alu_issue_valid |-> tag1_q[alu_idx] == '0 && tag2_q[alu_idx] == '0);

	a_mult_operands: assert property (@(posedge clock) disable iff (reset)
		mult_issue_valid |-> tag1_q[mult_idx] == '0 && tag2_q[mult_idx] == '0);

	// a broadcast must come from an entry that was actually sent to a unit
	a_cdb_owner: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> cdb_tag != '0 && busy_q[cdb_idx] && issued_q[cdb_idx]);

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              issue_valid,
	input  wire  tomasulo_pkg::opcode_e      issue_op,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   issue_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  a,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  b,
	output logic                             issue_ready,
	output logic                             done_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]   done_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  done_value,
	input  wire                              done_ready,
	output logic                             alu_idle
);
	import tomasulo_pkg::*;

	logic              full_q;
	logic [TAG_W-1:0]  tag_q;
	logic [DATA_W-1:0] result_q;
	logic [DATA_W-1:0] result;
	logic              issue_fire;

	always_comb begin
		case (issue_op)
			OP_ADD:  result = a + b;
			OP_SUB:  result = a - b;
			OP_AND:  result = a & b;
			OP_XOR:  result = a ^ b;
			default: result = '0;  // MUL never reaches this unit
		endcase
	end

	assign issue_ready = !full_q || done_ready;  // slot is empty or drains this cycle
	assign issue_fire  = issue_valid && issue_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			full_q <= 1'b0;
		end else if (issue_fire) begin
			full_q <= 1'b1;
		end else if (done_ready) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_fire) begin
			tag_q    <= issue_tag;
			result_q <= result;
		end
	end

	assign done_valid = full_q;
	assign done_tag   = tag_q;
	assign done_value = result_q;
	assign alu_idle   = !full_q;

	a_hold_result: assert property (@(posedge clock) disable iff (reset)
		done_valid && !done_ready |=> done_valid && $stable(done_value) && $stable(done_tag));

endmodule

`default_nettype wire

// File: verilog/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              issue_valid,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   issue_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  a,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  b,
	output logic                             done_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]   done_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  done_value,
	output logic                             mult_idle
);
	import tomasulo_pkg::*;

	logic [MULT_STAGES-1:0] valid_q;
	logic [TAG_W-1:0]       tag_q  [MULT_STAGES];
	logic [DATA_W-1:0]      prod_q [MULT_STAGES];

	// product is formed in the first stage and the later stages
	// give synthesis room to retime the multiplier
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= issue_valid;
			for (int s = 1; s < MULT_STAGES; s++) begin
				valid_q[s] <= valid_q[s-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		tag_q[0]  <= issue_tag;
		prod_q[0] <= a * b;  // low half of the product only
		for (int s = 1; s < MULT_STAGES; s++) begin
			tag_q[s]  <= tag_q[s-1];
			prod_q[s] <= prod_q[s-1];
		end
	end

	assign done_valid = valid_q[MULT_STAGES-1];
	assign done_tag   = tag_q[MULT_STAGES-1];
	assign done_value = prod_q[MULT_STAGES-1];
	assign mult_idle  = ~|valid_q;  // nothing in flight

endmodule

`default_nettype wire

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input  wire                              mult_done_valid,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   mult_done_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  mult_done_value,
	input  wire                              alu_done_valid,
	input  wire  [tomasulo_pkg::TAG_W-1:0]   alu_done_tag,
	input  wire  [tomasulo_pkg::DATA_W-1:0]  alu_done_value,
	output logic                             alu_done_ready,
	output logic                             cdb_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]   cdb_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  cdb_value
);

	// multiplier cannot stall, so it always wins the bus
	assign alu_done_ready = !mult_done_valid;
	assign cdb_valid      = mult_done_valid || alu_done_valid;

	always_comb begin
		if (mult_done_valid) begin
			cdb_tag   = mult_done_tag;
			cdb_value = mult_done_value;
		end else begin
			cdb_tag   = alu_done_tag;  // also the idle value, ignored while cdb_valid is low
			cdb_value = alu_done_value;
		end
	end

	// tag 0 means "value present" in rs and reg_status
	always_comb begin
		a_nonzero_tag: assert final (!cdb_valid || cdb_tag != '0);
	end

endmodule

`default_nettype wire

// File: verilog/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
	parameter int NUM_ALU_RS  = 3,
	parameter int NUM_MULT_RS = 2
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              dispatch_valid,
	input  wire  tomasulo_pkg::opcode_e      dispatch_op,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rd,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rs1,
	input  wire  [tomasulo_pkg::REG_W-1:0]   dispatch_rs2,
	output logic                             dispatch_ready,
	output logic                             cdb_valid,
	output logic [tomasulo_pkg::TAG_W-1:0]   cdb_tag,
	output logic [tomasulo_pkg::DATA_W-1:0]  cdb_value,
	output logic                             idle,
	input  wire  [tomasulo_pkg::REG_W-1:0]   read_addr,
	output logic [tomasulo_pkg::DATA_W-1:0]  read_data
);
	import tomasulo_pkg::*;

	logic              dispatch_fire;
	logic [TAG_W-1:0]  alloc_tag;
	logic [TAG_W-1:0]  src1_tag;
	logic [DATA_W-1:0] src1_value;
	logic [TAG_W-1:0]  src2_tag;
	logic [DATA_W-1:0] src2_value;

	logic              alu_issue_valid;
	logic              alu_issue_ready;
	opcode_e           alu_issue_op;
	logic [TAG_W-1:0]  alu_issue_tag;
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	logic              alu_done_valid;
	logic              alu_done_ready;
	logic [TAG_W-1:0]  alu_done_tag;
	logic [DATA_W-1:0] alu_done_value;
	logic              alu_idle;

	logic              mult_issue_valid;
	logic [TAG_W-1:0]  mult_issue_tag;
	logic [DATA_W-1:0] mult_a;
	logic [DATA_W-1:0] mult_b;
	logic              mult_done_valid;
	logic [TAG_W-1:0]  mult_done_tag;
	logic [DATA_W-1:0] mult_done_value;
	logic              mult_idle;

	logic              rs_empty;

	assign idle = rs_empty && alu_idle && mult_idle;

	reg_status u_reg_status (
		.clock         (clock),
		.reset         (reset),
		.dispatch_fire (dispatch_fire),
		.dispatch_rd   (dispatch_rd),
		.dispatch_rs1  (dispatch_rs1),
		.dispatch_rs2  (dispatch_rs2),
		.alloc_tag     (alloc_tag),
		.src1_tag      (src1_tag),
		.src1_value    (src1_value),
		.src2_tag      (src2_tag),
		.src2_value    (src2_value),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.read_addr     (read_addr),
		.read_data     (read_data)
	);

	rs #(
		.NUM_ALU_RS  (NUM_ALU_RS),
		.NUM_MULT_RS (NUM_MULT_RS)
	) u_rs (
		.clock            (clock),
		.reset            (reset),
		.dispatch_valid   (dispatch_valid),
		.dispatch_op      (dispatch_op),
		.src1_tag         (src1_tag),
		.src1_value       (src1_value),
		.src2_tag         (src2_tag),
		.src2_value       (src2_value),
		.dispatch_ready   (dispatch_ready),
		.dispatch_fire    (dispatch_fire),
		.alloc_tag        (alloc_tag),
		.alu_issue_valid  (alu_issue_valid),
		.alu_issue_op     (alu_issue_op),
		.alu_issue_tag    (alu_issue_tag),
		.alu_a            (alu_a),
		.alu_b            (alu_b),
		.alu_issue_ready  (alu_issue_ready),
		.mult_issue_valid (mult_issue_valid),
		.mult_issue_tag   (mult_issue_tag),
		.mult_a           (mult_a),
		.mult_b           (mult_b),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value),
		.rs_empty         (rs_empty)
	);

	alu_unit u_alu (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (alu_issue_valid),
		.issue_op    (alu_issue_op),
		.issue_tag   (alu_issue_tag),
		.a           (alu_a),
		.b           (alu_b),
		.issue_ready (alu_issue_ready),
		.done_valid  (alu_done_valid),
		.done_tag    (alu_done_tag),
		.done_value  (alu_done_value),
		.done_ready  (alu_done_ready),
		.alu_idle    (alu_idle)
	);

	mult_unit u_mult (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (mult_issue_valid),
		.issue_tag   (mult_issue_tag),
		.a           (mult_a),
		.b           (mult_b),
		.done_valid  (mult_done_valid),
		.done_tag    (mult_done_tag),
		.done_value  (mult_done_value),
		.mult_idle   (mult_idle)
	);

	cdb_arbiter u_cdb_arbiter (
		.mult_done_valid (mult_done_valid),
		.mult_done_tag   (mult_done_tag),
		.mult_done_value (mult_done_value),
		.alu_done_valid  (alu_done_valid),
		.alu_done_tag    (alu_done_tag),
		.alu_done_value  (alu_done_value),
		.alu_done_ready  (alu_done_ready),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.cdb_value       (cdb_value)
	);

endmodule

`default_nettype wire

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int NUM_ENTRIES = NUM_ALU_RS + NUM_MULT_RS;

logic [DATA_W-1:0] model_regs   [8];  // architectural state in program order
logic [DATA_W-1:0] expect_value [1:MAX_RS];
bit                pending      [1:MAX_RS];  // accepted, not yet broadcast
bit                entry_busy   [NUM_ENTRIES];
int                accepted_count;
int                broadcast_count;

function automatic logic [DATA_W-1:0] reference_result(input opcode_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
	logic [2*DATA_W-1:0] product;
	product = a * b;
	case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_XOR:  return a ^ b;
		default: return product[DATA_W-1:0];  // low half of the MUL
	endcase
endfunction

// alu entries sit below the multiplier entries and the lowest free one is taken
function automatic int lowest_free_tag(input opcode_e op);
	int first;
	int last;
	first = (op == OP_MUL) ? NUM_ALU_RS : 0;
	last  = (op == OP_MUL) ? NUM_ENTRIES - 1 : NUM_ALU_RS - 1;
	for (int i = first; i <= last; i++) begin
		if (!entry_busy[i]) return i + 1;
	end
	return 0;
endfunction

task automatic reset_model();
	for (int i = 0; i < 8; i++) model_regs[i] = DATA_W'(i);
	for (int t = 1; t <= MAX_RS; t++) pending[t] = 1'b0;
	for (int e = 0; e < NUM_ENTRIES; e++) entry_busy[e] = 1'b0;
	accepted_count  = 0;
	broadcast_count = 0;
endtask

task automatic model_dispatch(input opcode_e op, input logic [REG_W-1:0] rd,
		input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2);
	int                tag;
	logic [DATA_W-1:0] result;
	tag    = lowest_free_tag(op);
	result = reference_result(op, model_regs[rs1], model_regs[rs2]);
	model_regs[rd]      = result;
	expect_value[tag]   = result;
	pending[tag]        = 1'b1;
	entry_busy[tag - 1] = 1'b1;
	accepted_count++;
endtask

task automatic model_broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] value);
	check_value("cdb_tag pending", pending[tag], 1);
	check_value("cdb_value", value, expect_value[tag]);
	pending[tag] = 1'b0;
	if (tag >= 1 && tag <= NUM_ENTRIES) entry_busy[tag - 1] = 1'b0;
	broadcast_count++;
endtask

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("CHECK FAILED time=%0t signal=%s actual=%0h expected=%0h",
			$time, name, actual, expected);
		$display("Test FAILED");
		$fatal(1, "stopped at first mismatch");
	end
endtask

`endif

// File: tests/tb_tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_core;
	import tomasulo_pkg::*;

	localparam int NUM_ALU_RS     = 3;
	localparam int NUM_MULT_RS    = 2;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int NUM_INSTRS     = 300;
	localparam int MULT_LATENCY   = 1 + MULT_STAGES + 1;  // occupy, issue, pipe, broadcast

	logic              clock;
	logic              reset;
	logic              dispatch_valid;
	opcode_e           dispatch_op;
	logic [REG_W-1:0]  dispatch_rd;
	logic [REG_W-1:0]  dispatch_rs1;
	logic [REG_W-1:0]  dispatch_rs2;
	logic              dispatch_ready;
	logic              cdb_valid;
	logic [TAG_W-1:0]  cdb_tag;
	logic [DATA_W-1:0] cdb_value;
	logic              idle;
	logic [REG_W-1:0]  read_addr;
	logic [DATA_W-1:0] read_data;
	int                held_mul_cycles;
	int                latency;

	`include "tb_model.svh"

	tomasulo_core #(
		.NUM_ALU_RS  (NUM_ALU_RS),
		.NUM_MULT_RS (NUM_MULT_RS)
	) dut (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op),
		.dispatch_rd    (dispatch_rd),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_rs2   (dispatch_rs2),
		.dispatch_ready (dispatch_ready),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_value      (cdb_value),
		.idle           (idle),
		.read_addr      (read_addr),
		.read_data      (read_data)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// outputs are sampled mid-cycle while inputs change 2 ns after the rising edge
	always @(negedge clock) begin
		if (!reset) begin
			check_value("dispatch_ready", dispatch_ready, lowest_free_tag(dispatch_op) != 0);
			if (dispatch_valid && !dispatch_ready && dispatch_op == OP_MUL) held_mul_cycles++;
			if (dispatch_valid && dispatch_ready) begin
				model_dispatch(dispatch_op, dispatch_rd, dispatch_rs1, dispatch_rs2);
			end
			if (cdb_valid) model_broadcast(cdb_tag, cdb_value);
		end
	end

	task automatic report_timeout(input string what);
		$display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		$display("Test FAILED");
		$fatal(1, "wait limit reached");
	endtask

	// entered 2 ns after a rising edge and returns 2 ns after the handshake edge
	task automatic send_instr(input opcode_e op, input logic [REG_W-1:0] rd,
			input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2);
		int waited;
		waited         = 0;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_rd    = rd;
		dispatch_rs1   = rs1;
		dispatch_rs2   = rs2;
		@(negedge clock);
		while (!dispatch_ready) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) report_timeout("dispatch_ready");
			@(negedge clock);
		end
		@(posedge clock);
		#2;
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge clock);
		while (!idle) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) report_timeout("idle");
			@(negedge clock);
		end
	endtask

	task automatic wait_cdb_tag(input logic [TAG_W-1:0] tag, output int cycles);
		cycles = 1;
		@(negedge clock);
		while (!(cdb_valid && cdb_tag == tag)) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) report_timeout("a CDB broadcast of the MUL tag");
			@(negedge clock);
		end
	endtask

	task automatic compare_registers();
		for (int i = 0; i < 8; i++) begin
			@(posedge clock);
			#2;
			read_addr = REG_W'(i);
			@(negedge clock);
			check_value($sformatf("read_data[r%0d]", i), read_data, model_regs[i]);
		end
	endtask

	initial begin
		void'($urandom(80));
		reset_model();
		held_mul_cycles = 0;
		reset           = 1'b1;
		dispatch_valid  = 1'b0;
		dispatch_op     = OP_ADD;
		dispatch_rd     = '0;
		dispatch_rs1    = '0;
		dispatch_rs2    = '0;
		read_addr       = '0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		@(negedge clock);
		check_value("dispatch_ready", dispatch_ready, 1);
		check_value("idle", idle, 1);
		check_value("cdb_valid", cdb_valid, 0);
		compare_registers();  // model still holds the reset values

		@(posedge clock);
		#2;
		for (int n = 0; n < NUM_INSTRS; n++) begin
			send_instr(opcode_e'($urandom_range(0, 4)), REG_W'($urandom_range(0, 7)),
				REG_W'($urandom_range(0, 7)), REG_W'($urandom_range(0, 7)));
			if ($urandom_range(0, 3) == 0) begin
				repeat ($urandom_range(1, 3)) @(posedge clock);
				#2;
			end
		end
		wait_idle();
		compare_registers();

		// dependent MUL chain fills the multiplier entries while ALU work slips in between
		held_mul_cycles = 0;
		@(posedge clock);
		#2;
		send_instr(OP_MUL, 3'd1, 3'd1, 3'd2);
		send_instr(OP_ADD, 3'd3, 3'd1, 3'd4);
		send_instr(OP_MUL, 3'd1, 3'd1, 3'd1);
		send_instr(OP_SUB, 3'd5, 3'd5, 3'd6);
		send_instr(OP_MUL, 3'd2, 3'd1, 3'd3);
		send_instr(OP_XOR, 3'd6, 3'd3, 3'd2);
		wait_idle();
		check_value("held MUL seen", held_mul_cycles != 0, 1);
		compare_registers();

		// lone MUL into an empty core
		@(posedge clock);
		#2;
		send_instr(OP_MUL, 3'd4, 3'd5, 3'd6);
		wait_cdb_tag(TAG_W'(NUM_ALU_RS + 1), latency);
		check_value("MUL dispatch to CDB cycles", latency, MULT_LATENCY);
		wait_idle();
		compare_registers();
		check_value("broadcast_count", broadcast_count, accepted_count);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tomasulo_core.f
+incdir+tests
verilog/tomasulo_pkg.sv
verilog/reg_status.sv
verilog/rs.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/cdb_arbiter.sv
verilog/tomasulo_core.sv
tests/tb_tomasulo_core.sv
